/* hw/dcache_params.svh */
// Geometry and word width of the direct-mapped data cache
// Address fields are {tag, index, offset} of a word address

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Cache organisation
`define DCACHE_SETS         16
`define DCACHE_LINE_WORDS   4
`define DCACHE_WORD_BITS    32

// Word address and its fields
`define DCACHE_ADDR_BITS    12
`define DCACHE_IDX_BITS     4
`define DCACHE_OFF_BITS     2
`define DCACHE_TAG_BITS     6
`define DCACHE_MAX_IDX      15

`endif

/* hw/dcache_pkg.sv */
// Shared data cache types: address fields, data word and line,
// and the state encoding of the cache controller

`include "dcache_params.svh"

package dcache_pkg;

    // Word address, split as {tag, index, offset}
    typedef logic [`DCACHE_ADDR_BITS-1:0] dcache_addr_t;

    // Set index into the tag and data arrays
    typedef logic [`DCACHE_IDX_BITS-1:0] dcache_idx_t;

    // Tag stored per set
    typedef logic [`DCACHE_TAG_BITS-1:0] dcache_tag_t;

    // One data word as seen by the load/store unit
    typedef logic [`DCACHE_WORD_BITS-1:0] dcache_word_t;

    // Full cache line, word 0 in the low bits
    typedef logic [`DCACHE_LINE_WORDS*`DCACHE_WORD_BITS-1:0] dcache_line_t;

    // Controller FSM states
    typedef enum logic [2:0] {
        DCACHE_IDLE,
        DCACHE_READ,
        DCACHE_WRITE,
        DCACHE_ALLOCATE,
        DCACHE_WRITE_BACK,
        DCACHE_FLUSH,
        DCACHE_FLUSH_DONE
    } dcache_state_e;

endpackage

/* hw/dcache_ctrl_if.sv */
// Status and command signals between cache controller and datapath

`timescale 1ns/1ns

interface dcache_ctrl_if;

    // Status from the datapath
    logic                    cache_hit;
    logic                    cache_evict_req;

    // Commands from the controller
    logic                    cache_wr;
    logic                    cache_line_wr;
    logic                    cache_line_clean;
    logic                    cache_wrb_req;
    logic                    flushing;
    dcache_pkg::dcache_idx_t evict_index;

    modport controller (
        input  cache_hit, cache_evict_req,
        output cache_wr, cache_line_wr, cache_line_clean, cache_wrb_req,
        output flushing, evict_index
    );

    modport datapath (
        output cache_hit, cache_evict_req,
        input  cache_wr, cache_line_wr, cache_line_clean, cache_wrb_req,
        input  flushing, evict_index
    );

endinterface

/* hw/wb_dcache_controller.sv */
// Control FSM of the write-back data cache
// Sequences hits, refills, dirty write-back and the full-cache flush

`timescale 1ns/1ns

`include "dcache_params.svh"

module wb_dcache_controller (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              lsu_req_i,
    input  logic              lsu_wr_i,
    input  logic              dmem_sel_i,
    input  logic              dcache_flush_i,
    input  logic              mem_ack_i,
    output logic              lsu_ack_o,
    output logic              mem_req_o,
    output logic              mem_wr_o,
    dcache_ctrl_if.controller ctrl
);

    dcache_pkg::dcache_state_e state_q, state_d;
    dcache_pkg::dcache_idx_t   evict_index_q, evict_index_d;

    logic req_hit;
    logic req_miss;
    logic cache_wr;
    logic cache_line_wr;
    logic cache_line_clean;
    logic cache_wrb_req;

    // Only an addressed request counts as hit or miss
    assign req_hit  = lsu_req_i & dmem_sel_i & ctrl.cache_hit;
    assign req_miss = lsu_req_i & dmem_sel_i & ~ctrl.cache_hit;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= dcache_pkg::DCACHE_IDLE;
            evict_index_q <= '0;
        end else begin
            state_q       <= state_d;
            evict_index_q <= evict_index_d;
        end
    end

    always_comb begin
        state_d          = state_q;
        evict_index_d    = evict_index_q;
        lsu_ack_o        = 1'b0;
        mem_req_o        = 1'b0;
        mem_wr_o         = 1'b0;
        cache_wr         = 1'b0;
        cache_line_wr    = 1'b0;
        cache_line_clean = 1'b0;
        cache_wrb_req    = 1'b0;

        unique case (state_q)
            dcache_pkg::DCACHE_IDLE: begin
                if (dcache_flush_i) begin
                    state_d = dcache_pkg::DCACHE_FLUSH;
                end else if (req_hit) begin
                    // Write data goes into the line at this same edge
                    cache_wr = lsu_wr_i;
                    state_d  = lsu_wr_i ? dcache_pkg::DCACHE_WRITE : dcache_pkg::DCACHE_READ;
                end else if (req_miss) begin
                    if (ctrl.cache_evict_req) begin
                        state_d       = dcache_pkg::DCACHE_WRITE_BACK;
                        mem_req_o     = 1'b1;
                        mem_wr_o      = 1'b1;
                        cache_wrb_req = 1'b1;
                    end else begin
                        state_d = dcache_pkg::DCACHE_ALLOCATE;
                    end
                end else begin
                    evict_index_d = '0;
                end
            end
            dcache_pkg::DCACHE_READ, dcache_pkg::DCACHE_WRITE: begin
                lsu_ack_o = 1'b1;
                state_d   = dcache_pkg::DCACHE_IDLE;
            end
            dcache_pkg::DCACHE_ALLOCATE: begin
                if (mem_ack_i) begin
                    // Refill line lands now, the hit path follows from idle
                    cache_line_wr = 1'b1;
                    state_d       = dcache_pkg::DCACHE_IDLE;
                end else begin
                    mem_req_o = 1'b1;
                end
            end
            dcache_pkg::DCACHE_WRITE_BACK: begin
                if (mem_ack_i) begin
                    if (dcache_flush_i) begin
                        // Recheck the same index once it is clean
                        cache_line_clean = 1'b1;
                        state_d          = dcache_pkg::DCACHE_FLUSH;
                    end else begin
                        state_d = dcache_pkg::DCACHE_ALLOCATE;
                    end
                end else begin
                    mem_req_o     = 1'b1;
                    mem_wr_o      = 1'b1;
                    cache_wrb_req = 1'b1;
                end
            end
            dcache_pkg::DCACHE_FLUSH: begin
                if (ctrl.cache_evict_req) begin
                    state_d       = dcache_pkg::DCACHE_WRITE_BACK;
                    mem_req_o     = 1'b1;
                    mem_wr_o      = 1'b1;
                    cache_wrb_req = 1'b1;
                end else if (evict_index_q == dcache_pkg::dcache_idx_t'(`DCACHE_MAX_IDX)) begin
                    evict_index_d = '0;
                    state_d       = dcache_pkg::DCACHE_FLUSH_DONE;
                end else begin
                    evict_index_d = evict_index_q + 1'b1;
                end
            end
            dcache_pkg::DCACHE_FLUSH_DONE: begin
                lsu_ack_o = 1'b1;
                state_d   = dcache_pkg::DCACHE_IDLE;
            end
            default: begin
                state_d = dcache_pkg::DCACHE_IDLE;
            end
        endcase

        // Deselected data memory aborts whatever is in progress
        if (!dmem_sel_i) begin
            state_d          = dcache_pkg::DCACHE_IDLE;
            evict_index_d    = '0;
            lsu_ack_o        = 1'b0;
            mem_req_o        = 1'b0;
            mem_wr_o         = 1'b0;
            cache_wr         = 1'b0;
            cache_line_wr    = 1'b0;
            cache_line_clean = 1'b0;
            cache_wrb_req    = 1'b0;
        end
    end

    assign ctrl.cache_wr         = cache_wr;
    assign ctrl.cache_line_wr    = cache_line_wr;
    assign ctrl.cache_line_clean = cache_line_clean;
    assign ctrl.cache_wrb_req    = cache_wrb_req;
    assign ctrl.evict_index      = evict_index_q;

    // Victim comes from the evict index for the whole flush sequence
    assign ctrl.flushing = (state_q == dcache_pkg::DCACHE_FLUSH)
                         | (state_q == dcache_pkg::DCACHE_FLUSH_DONE)
                         | ((state_q == dcache_pkg::DCACHE_WRITE_BACK) & dcache_flush_i);

endmodule

/* hw/wb_dcache_datapath.sv */
// Tag, valid, dirty and data arrays of the direct-mapped data cache
// Hit and evict detection, memory address and write-back data selection

`timescale 1ns/1ns

`include "dcache_params.svh"

module wb_dcache_datapath (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  dcache_pkg::dcache_addr_t                      lsu_addr_i,
    input  dcache_pkg::dcache_word_t                      lsu_wdata_i,
    input  dcache_pkg::dcache_line_t                      mem_rdata_i,
    output dcache_pkg::dcache_word_t                      lsu_rdata_o,
    output logic [`DCACHE_TAG_BITS+`DCACHE_IDX_BITS-1:0]  mem_addr_o,
    output dcache_pkg::dcache_line_t                      mem_wdata_o,
    dcache_ctrl_if.datapath                               ctrl
);

    dcache_pkg::dcache_tag_t     tag_q  [`DCACHE_SETS];
    dcache_pkg::dcache_line_t    data_q [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]     valid_q;
    logic [`DCACHE_SETS-1:0]     dirty_q;

    dcache_pkg::dcache_tag_t     req_tag;
    dcache_pkg::dcache_idx_t     req_idx;
    logic [`DCACHE_OFF_BITS-1:0] req_off;
    dcache_pkg::dcache_idx_t     victim_idx;
    dcache_pkg::dcache_line_t    req_line;

    // Word address fields
    assign {req_tag, req_idx, req_off} = lsu_addr_i;

    // Flush walks the evict index, a miss replaces the requested set
    assign victim_idx = ctrl.flushing ? ctrl.evict_index : req_idx;

    assign ctrl.cache_hit = valid_q[req_idx] & (tag_q[req_idx] == req_tag);

    // A miss only evicts a dirty line that belongs to another tag
    assign ctrl.cache_evict_req = valid_q[victim_idx] & dirty_q[victim_idx]
                                & (ctrl.flushing | (tag_q[req_idx] != req_tag));

    // Read word from the requested line
    assign req_line    = data_q[req_idx];
    assign lsu_rdata_o = req_line[req_off*`DCACHE_WORD_BITS +: `DCACHE_WORD_BITS];

    // Victim line address during write-back, else the request line
    always_comb begin
        if (ctrl.cache_wrb_req) begin
            mem_addr_o = {tag_q[victim_idx], victim_idx};
        end else begin
            mem_addr_o = {req_tag, req_idx};
        end
    end

    assign mem_wdata_o = data_q[victim_idx];

    // Line state bits
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (ctrl.cache_line_wr) begin
                // Fresh refill is valid and clean
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;
            end
            if (ctrl.cache_wr) begin
                dirty_q[req_idx] <= 1'b1;
            end
            if (ctrl.cache_line_clean) begin
                dirty_q[ctrl.evict_index] <= 1'b0;
            end
        end
    end

    // Tag and data storage
    always_ff @(posedge clk_i) begin
        if (ctrl.cache_line_wr) begin
            tag_q[req_idx]  <= req_tag;
            data_q[req_idx] <= mem_rdata_i;
        end else if (ctrl.cache_wr) begin
            data_q[req_idx][req_off*`DCACHE_WORD_BITS +: `DCACHE_WORD_BITS] <= lsu_wdata_i;
        end
    end

endmodule

/* hw/wb_dcache_top.sv */
// Write-back data cache top level
// Controller and datapath joined by the control interface

`timescale 1ns/1ns

`include "dcache_params.svh"

module wb_dcache_top (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,

    // Load/store unit side
    input  logic                                          lsu_req_i,
    input  logic                                          lsu_wr_i,
    input  dcache_pkg::dcache_addr_t                      lsu_addr_i,
    input  dcache_pkg::dcache_word_t                      lsu_wdata_i,
    input  logic                                          dmem_sel_i,
    input  logic                                          dcache_flush_i,
    output logic                                          lsu_ack_o,
    output dcache_pkg::dcache_word_t                      lsu_rdata_o,

    // Line-wide main memory side
    output logic                                          mem_req_o,
    output logic                                          mem_wr_o,
    output logic [`DCACHE_TAG_BITS+`DCACHE_IDX_BITS-1:0]  mem_addr_o,
    output dcache_pkg::dcache_line_t                      mem_wdata_o,
    input  logic                                          mem_ack_i,
    input  dcache_pkg::dcache_line_t                      mem_rdata_i
);

    dcache_ctrl_if ctrl_if ();

    wb_dcache_controller i_controller (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lsu_req_i      (lsu_req_i),
        .lsu_wr_i       (lsu_wr_i),
        .dmem_sel_i     (dmem_sel_i),
        .dcache_flush_i (dcache_flush_i),
        .mem_ack_i      (mem_ack_i),
        .lsu_ack_o      (lsu_ack_o),
        .mem_req_o      (mem_req_o),
        .mem_wr_o       (mem_wr_o),
        .ctrl           (ctrl_if.controller)
    );

    wb_dcache_datapath i_datapath (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .mem_rdata_i (mem_rdata_i),
        .lsu_rdata_o (lsu_rdata_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .ctrl        (ctrl_if.datapath)
    );

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock (4 ns period) and active-low reset held for 10 cycles

`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* verification/tb_dcache_checker.sv */
// Checker module with the shadow word memory, main memory image and cache tag model
// Reference read value, comparison of DUT responses, test reports and timeout

`timescale 1ns/1ns

`include "dcache_params.svh"

module tb_dcache_checker (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     lsu_req_i,
    input  logic                     lsu_wr_i,
    input  dcache_pkg::dcache_addr_t lsu_addr_i,
    input  dcache_pkg::dcache_word_t lsu_wdata_i,
    input  logic                     dmem_sel_i,
    input  logic                     dcache_flush_i,
    input  logic                     lsu_ack_i,
    input  dcache_pkg::dcache_word_t lsu_rdata_i,
    input  logic                     mem_req_i,
    input  logic                     mem_wr_i,
    input  logic [9:0]               mem_addr_i,
    input  dcache_pkg::dcache_line_t mem_wdata_i,
    input  logic                     mem_ack_i,
    input  int                       test_id_i,
    input  logic                     done_i,
    output int                       errors_o,
    output logic                     report_done_o,
    output logic                     timed_out_o
);

    // About 250 operations of at most 12 cycles each plus margin
    localparam int timeout_cycles = 20000;

    dcache_pkg::dcache_word_t word_mem [int];
    dcache_pkg::dcache_word_t main_img [int];
    dcache_pkg::dcache_tag_t  model_tag [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]  model_valid;
    logic [`DCACHE_SETS-1:0]  model_dirty;

    // Memory request captured while held and used at its acknowledge
    logic                     pend_wr;
    logic [9:0]               pend_addr;
    dcache_pkg::dcache_line_t pend_data;

    int   cycles = 0;
    int   cur_test;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    logic out_checked;

    function automatic dcache_pkg::dcache_word_t initial_word(input dcache_pkg::dcache_addr_t a);
        return {4'ha, a, 4'h5, ~a};
    endfunction

    // Reference read value is the last write to the address or the initial pattern
    function automatic dcache_pkg::dcache_word_t expected_word(input dcache_pkg::dcache_addr_t a);
        if (word_mem.exists(int'(a))) begin
            return word_mem[int'(a)];
        end
        return initial_word(a);
    endfunction

    function automatic dcache_pkg::dcache_line_t expected_line(input logic [9:0] l);
        dcache_pkg::dcache_line_t line;
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            line[w*`DCACHE_WORD_BITS +: `DCACHE_WORD_BITS] = expected_word({l, 2'(w)});
        end
        return line;
    endfunction

    task automatic note_error(input string msg);
        $display("Cycle %0d, test %0d: %s", cycles, cur_test, msg);
        errors_o++;
        test_errors++;
    endtask

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
        errors_o++;
        test_errors++;
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
            end
            $display("Test %0d %s with %0d errors", cur_test,
                     (test_errors == 0) ? "passed" : "failed", test_errors);
        end
        test_errors = 0;
    endtask

    // Completed memory transaction with the line address as {tag, index}
    task automatic check_memory();
        dcache_pkg::dcache_idx_t idx;
        dcache_pkg::dcache_tag_t tag;
        idx = pend_addr[3:0];
        tag = pend_addr[9:4];
        if (pend_wr) begin
            if (!model_valid[idx] || !model_dirty[idx] || model_tag[idx] != tag) begin
                note_error($sformatf("write-back of line %0h that is not dirty", pend_addr));
            end else if (!dcache_flush_i && idx != lsu_addr_i[5:2]) begin
                note_error("write-back of a set other than the requested one");
            end else if (!dcache_flush_i && tag == lsu_addr_i[11:6]) begin
                note_error("write-back of the line that the request hits");
            end
            if (pend_data !== expected_line(pend_addr)) begin
                value_error("mem_wdata_o", pend_data, expected_line(pend_addr));
            end
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                main_img[int'({pend_addr, 2'(w)})] = pend_data[w*32 +: 32];
            end
            model_dirty[idx] = 1'b0;
        end else if (dcache_flush_i) begin
            note_error("refill during a flush");
        end else if (pend_addr !== lsu_addr_i[11:2]) begin
            value_error("mem_addr_o", pend_addr, lsu_addr_i[11:2]);
        end else begin
            if (model_valid[idx] && (model_tag[idx] == tag || model_dirty[idx])) begin
                note_error("refill of a line that hits or still holds dirty data");
            end
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            model_dirty[idx] = 1'b0;
        end
    endtask

    task automatic check_ack();
        dcache_pkg::dcache_idx_t  idx;
        dcache_pkg::dcache_word_t img;
        idx = lsu_addr_i[5:2];
        if (dcache_flush_i) begin
            if (model_dirty != '0) begin
                note_error("flush acknowledged with dirty lines left in the cache");
            end
            foreach (word_mem[a]) begin
                img = main_img.exists(a) ? main_img[a] : initial_word(12'(a));
                if (img !== word_mem[a]) begin
                    value_error($sformatf("main memory word %0h", a), img, word_mem[a]);
                end
            end
        end else if (!lsu_req_i) begin
            note_error("acknowledge without a request");
        end else begin
            if (!model_valid[idx] || model_tag[idx] != lsu_addr_i[11:6]) begin
                note_error("acknowledge before the line was refilled");
            end
            if (lsu_wr_i) begin
                word_mem[int'(lsu_addr_i)] = lsu_wdata_i;
                model_dirty[idx]           = 1'b1;
            end else if (lsu_rdata_i !== expected_word(lsu_addr_i)) begin
                value_error("lsu_rdata_o", lsu_rdata_i, expected_word(lsu_addr_i));
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (!rst_ni) begin
            model_valid   = '0;
            model_dirty   = '0;
            pend_wr       = 1'b0;
            pend_addr     = '0;
            pend_data     = '0;
            cur_test      = 0;
            test_errors   = 0;
            tests_run     = 0;
            tests_failed  = 0;
            out_checked   = 1'b0;
            errors_o      = 0;
            report_done_o = 1'b0;
            timed_out_o   = 1'b0;
        end else if (!timed_out_o && !report_done_o) begin
            if (cycles > timeout_cycles) begin
                $display("Timeout: tests still running after %0d cycles", timeout_cycles);
                timed_out_o = 1'b1;
            end else begin
                if (!out_checked && (lsu_ack_i || mem_req_i || mem_wr_i)) begin
                    note_error("acknowledge or memory request high right after reset");
                end
                out_checked = 1'b1;
                if (test_id_i != cur_test) begin
                    close_test();
                    cur_test = test_id_i;
                end
                if (!dmem_sel_i && (lsu_ack_i || mem_req_i)) begin
                    note_error("acknowledge or memory request while data memory is deselected");
                end
                if (mem_req_i) begin
                    pend_wr   = mem_wr_i;
                    pend_addr = mem_addr_i;
                    pend_data = mem_wdata_i;
                end
                if (mem_ack_i) begin
                    check_memory();
                end
                if (lsu_ack_i) begin
                    check_ack();
                end
                if (done_i) begin
                    close_test();
                    $display("Tests run %0d, failed %0d, errors %0d",
                             tests_run, tests_failed, errors_o);
                    report_done_o = 1'b1;
                end
            end
        end
    end

endmodule

/* verification/tb_dcache_top.sv */
// Testbench top with clock and reset, DUT, checker and line memory model
// Directed and random stimulus driven on falling clock edges

`timescale 1ns/1ns

`include "dcache_params.svh"

module tb_dcache_top;

    localparam int mem_latency = 3;
    localparam int mem_lines   = 1 << (`DCACHE_TAG_BITS + `DCACHE_IDX_BITS);

    logic                                         clk;
    logic                                         rst_n;
    logic                                         lsu_req;
    logic                                         lsu_wr;
    dcache_pkg::dcache_addr_t                     lsu_addr;
    dcache_pkg::dcache_word_t                     lsu_wdata;
    logic                                         dmem_sel;
    logic                                         dcache_flush;
    logic                                         lsu_ack;
    dcache_pkg::dcache_word_t                     lsu_rdata;
    logic                                         mem_req;
    logic                                         mem_req_q = 1'b0;
    logic                                         mem_wr;
    logic [`DCACHE_TAG_BITS+`DCACHE_IDX_BITS-1:0] mem_addr;
    dcache_pkg::dcache_line_t                     mem_wdata;
    logic                                         mem_ack = 1'b0;
    dcache_pkg::dcache_line_t                     mem_rdata = '0;
    dcache_pkg::dcache_line_t                     line_mem [mem_lines];
    int                                           mem_wait = 0;
    int                                           test_id;
    logic                                         all_done;
    logic                                         report_done;
    logic                                         timed_out;
    int                                           error_count;
    int                                           seed = 72;

    tb_clock_gen i_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    wb_dcache_top i_dut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .lsu_req_i      (lsu_req),
        .lsu_wr_i       (lsu_wr),
        .lsu_addr_i     (lsu_addr),
        .lsu_wdata_i    (lsu_wdata),
        .dmem_sel_i     (dmem_sel),
        .dcache_flush_i (dcache_flush),
        .lsu_ack_o      (lsu_ack),
        .lsu_rdata_o    (lsu_rdata),
        .mem_req_o      (mem_req),
        .mem_wr_o       (mem_wr),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .mem_ack_i      (mem_ack),
        .mem_rdata_i    (mem_rdata)
    );

    tb_dcache_checker i_checker (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .lsu_req_i      (lsu_req),
        .lsu_wr_i       (lsu_wr),
        .lsu_addr_i     (lsu_addr),
        .lsu_wdata_i    (lsu_wdata),
        .dmem_sel_i     (dmem_sel),
        .dcache_flush_i (dcache_flush),
        .lsu_ack_i      (lsu_ack),
        .lsu_rdata_i    (lsu_rdata),
        .mem_req_i      (mem_req),
        .mem_wr_i       (mem_wr),
        .mem_addr_i     (mem_addr),
        .mem_wdata_i    (mem_wdata),
        .mem_ack_i      (mem_ack),
        .test_id_i      (test_id),
        .done_i         (all_done),
        .errors_o       (error_count),
        .report_done_o  (report_done),
        .timed_out_o    (timed_out)
    );

    // Main memory starts with a pattern of the whole word address
    initial begin
        for (int l = 0; l < mem_lines; l++) begin
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                line_mem[l][w*32 +: 32] = {4'ha, 10'(l), 2'(w), 4'h5, ~{10'(l), 2'(w)}};
            end
        end
    end

    // Memory request as the DUT held it at the rising edge
    always @(posedge clk) begin
        mem_req_q <= mem_req;
    end

    // Line memory that acknowledges a held request on the third falling edge
    always @(negedge clk) begin
        if (mem_ack) begin
            mem_ack  = 1'b0;
            mem_wait = 0;
        end else if (mem_req_q) begin
            if (mem_wait == mem_latency - 1) begin
                mem_rdata = line_mem[mem_addr];
                if (mem_wr) begin
                    line_mem[mem_addr] = mem_wdata;
                end
                mem_ack  = 1'b1;
                mem_wait = 0;
            end else begin
                mem_wait = mem_wait + 1;
            end
        end
    end

    // The request drops in the cycle after the acknowledge
    task automatic wait_ack();
        @(negedge clk);
        while (!lsu_ack) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic access(input logic wr, input dcache_pkg::dcache_addr_t addr,
                          input dcache_pkg::dcache_word_t wdata);
        lsu_req   = 1'b1;
        lsu_wr    = wr;
        lsu_addr  = addr;
        lsu_wdata = wdata;
        wait_ack();
        lsu_req = 1'b0;
    endtask

    task automatic flush_cache();
        dcache_flush = 1'b1;
        wait_ack();
        dcache_flush = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        lsu_req      = 1'b0;
        lsu_wr       = 1'b0;
        lsu_addr     = '0;
        lsu_wdata    = '0;
        dmem_sel     = 1'b1;
        dcache_flush = 1'b0;
        test_id      = 0;
        all_done     = 1'b0;
        @(posedge rst_n);
        @(negedge clk);

        test_id = 1;
        access(1'b0, 12'h010, '0);
        access(1'b0, 12'h010, '0);
        test_id = 2;
        access(1'b1, 12'h011, 32'hdeadbeef);
        access(1'b0, 12'h011, '0);
        // Set 4 again with tag 1 so the dirty tag 0 line goes out first
        test_id = 3;
        access(1'b0, 12'h050, '0);
        access(1'b0, 12'h011, '0);
        test_id = 4;
        for (int i = 0; i < 8; i++) begin
            access(1'b1, 12'(i * 37), 32'h0f00_0000 + i);
        end
        flush_cache();
        flush_cache();

        test_id  = 5;
        dmem_sel = 1'b0;
        lsu_req  = 1'b1;
        lsu_wr   = 1'b0;
        lsu_addr = 12'h123;
        repeat (20) @(negedge clk);
        lsu_req  = 1'b0;
        dmem_sel = 1'b1;
        @(negedge clk);

        // Only 4 tags over 4 sets to make conflicts and write-backs frequent
        test_id = 6;
        for (int i = 0; i < 160; i++) begin
            r = $random(seed);
            access(r[6], {4'b0, r[5:4], 2'b0, r[3:0]}, $random(seed));
        end
        flush_cache();
        all_done = 1'b1;
    end

    initial begin
        wait (report_done || timed_out);
        if (!timed_out && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ctrl_if.sv
hw/wb_dcache_controller.sv
hw/wb_dcache_datapath.sv
hw/wb_dcache_top.sv
verification/tb_clock_gen.sv
verification/tb_dcache_checker.sv
verification/tb_dcache_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_dcache_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
HEADERS   = $(wildcard hw/*.svh)

.PHONY: run clean

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
